//--- rv32i_pkg.sv
package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int INST_BYTES = 4;  // pc step per instruction

    // major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // {funct7, funct3} for OP-IMM
    typedef enum logic [9:0] {
        F_ADDI  = {7'b0000000, 3'b000},
        F_SLTI  = {7'b0000000, 3'b010},
        F_SLTIU = {7'b0000000, 3'b011},
        F_XORI  = {7'b0000000, 3'b100},
        F_ORI   = {7'b0000000, 3'b110},
        F_ANDI  = {7'b0000000, 3'b111},
        F_SLLI  = {7'b0000000, 3'b001},
        F_SRLI  = {7'b0000000, 3'b101},
        F_SRAI  = {7'b0100000, 3'b101}
    } itype_funct_t;

    // {funct7, funct3} for OP
    typedef enum logic [9:0] {
        F_ADD  = {7'b0000000, 3'b000},
        F_SUB  = {7'b0100000, 3'b000},
        F_SLL  = {7'b0000000, 3'b001},
        F_SLT  = {7'b0000000, 3'b010},
        F_SLTU = {7'b0000000, 3'b011},
        F_XOR  = {7'b0000000, 3'b100},
        F_SRL  = {7'b0000000, 3'b101},
        F_SRA  = {7'b0100000, 3'b101},
        F_OR   = {7'b0000000, 3'b110},
        F_AND  = {7'b0000000, 3'b111}
    } rtype_funct_t;

    typedef enum logic [2:0] {
        LD_LB  = 3'b000,
        LD_LH  = 3'b001,
        LD_LW  = 3'b010,
        LD_LBU = 3'b100,
        LD_LHU = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        ST_SB = 3'b000,
        ST_SH = 3'b001,
        ST_SW = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_funct3_t;

    // classes with a golden result
    typedef enum logic [2:0] {
        OP_XORI  = 3'd0,
        OP_AUIPC = 3'd1,
        OP_JAL   = 3'd2,
        OP_BLT   = 3'd3,
        OP_LB    = 3'd4,
        OP_OTHER = 3'd5
    } op_kind_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] mem_word;
    } retire_req_t;

    typedef struct packed {
        logic [6:0]      opcode;   // raw, may be illegal
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [XLEN-1:0] imm_u;
        logic [31:0]     inst;
        logic [31:0]     pc;
        logic [31:0]     rs1_val;
        logic [31:0]     rs2_val;
        logic [31:0]     mem_word;
    } decoded_t;

    typedef struct packed {
        logic        valid;
        logic        inst_ok;
        op_kind_t    op;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] rd_val;
        logic [31:0] mem_addr;
        logic [31:0] next_pc;
    } retire_rsp_t;

endpackage

//--- inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  rv32i_pkg::retire_req_t req_i,
    output rv32i_pkg::decoded_t    stage1_o,
    output logic                   s1_valid_o
);
    import rv32i_pkg::*;

    decoded_t   dec;
    logic [31:0] w;

    assign w = req_i.inst;

    // field slicing and immediate assembly
    always_comb begin
        dec.opcode   = w[6:0];
        dec.rd       = w[11:7];
        dec.funct3   = w[14:12];
        dec.funct7   = w[31:25];
        dec.imm_i    = {{(XLEN-12){w[31]}}, w[31:20]};
        dec.imm_b    = {{(XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        dec.imm_j    = {{(XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        dec.imm_u    = {w[31:12], 12'b0};  // upper 20, low bits zero
        dec.inst     = w;
        dec.pc       = req_i.pc;
        dec.rs1_val  = req_i.rs1_val;
        dec.rs2_val  = req_i.rs2_val;
        dec.mem_word = req_i.mem_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= req_i.valid;
        end
    end

    // payload loads every cycle, qualified by s1_valid_o
    always_ff @(posedge clk) begin
        stage1_o <= dec;
    end

endmodule

//--- inst_validator.sv
`timescale 1ns/100ps

module inst_validator (
    input  rv32i_pkg::decoded_t stage1_i,
    output logic                inst_ok_o
);
    import rv32i_pkg::*;

    logic [9:0]  funct_comb;
    logic [31:0] w;
    logic        fence_ok;
    logic        system_ok;
    logic        op_imm_ok;

    assign funct_comb = {stage1_i.funct7, stage1_i.funct3};
    assign w          = stage1_i.inst;

    // FENCE with fm zero, any pred/succ; FENCE.I fully fixed
    assign fence_ok = (w ==? 32'b0000_????_????_00000_000_00000_0001111) ||
                      (w == 32'b000000000000_00000_001_00000_0001111);

    // ECALL / EBREAK differ only in bit 20
    assign system_ok = (w[31:21] == 11'b0) && (w[19:7] == 13'b0);

    // shifts pin funct7, the other immediate ops take any imm
    always_comb begin
        if (stage1_i.funct3 == 3'b001 || stage1_i.funct3 == 3'b101) begin
            op_imm_ok = funct_comb inside {F_SLLI, F_SRLI, F_SRAI};
        end else begin
            op_imm_ok = 1'b1;
        end
    end

    always_comb begin
        case (stage1_i.opcode)
            OPC_LUI: inst_ok_o = 1'b1;
            OPC_AUIPC: inst_ok_o = 1'b1;
            OPC_JAL: inst_ok_o = (stage1_i.imm_j[1:0] == 2'b00);
            OPC_JALR: begin
                inst_ok_o = (stage1_i.funct3 == 3'b000) && (stage1_i.imm_i[1:0] == 2'b00);
            end
            OPC_BRANCH: begin
                inst_ok_o = (stage1_i.funct3 inside {BR_BEQ, BR_BNE, BR_BLT,
                                                     BR_BGE, BR_BLTU, BR_BGEU}) &&
                            (stage1_i.imm_b[1:0] == 2'b00);
            end
            OPC_LOAD: begin
                inst_ok_o = stage1_i.funct3 inside {LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU};
            end
            OPC_STORE: inst_ok_o = stage1_i.funct3 inside {ST_SB, ST_SH, ST_SW};
            OPC_OP_IMM: inst_ok_o = op_imm_ok;
            OPC_OP: begin
                inst_ok_o = funct_comb inside {F_ADD, F_SUB, F_SLL, F_SLT, F_SLTU,
                                               F_XOR, F_SRL, F_SRA, F_OR, F_AND};
            end
            OPC_FENCE: inst_ok_o = fence_ok;
            OPC_SYSTEM: inst_ok_o = system_ok;
            default: inst_ok_o = 1'b0;  // unknown major opcode
        endcase
    end

endmodule

//--- retire_ctrl.sv
`timescale 1ns/100ps

module retire_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  rv32i_pkg::decoded_t stage1_i,
    input  logic                s1_valid_i,
    input  logic                inst_ok_i,
    output rv32i_pkg::op_kind_t op_o,
    output logic                rsp_valid_o,
    output logic                rsp_ok_o,
    output rv32i_pkg::op_kind_t rsp_op_o,
    output logic [4:0]          rsp_rd_o,
    output logic                rsp_rd_we_o
);
    import rv32i_pkg::*;

    logic writes_rd;

    // classify, illegal words fall to OP_OTHER
    always_comb begin
        op_o = OP_OTHER;
        if (inst_ok_i) begin
            case (stage1_i.opcode)
                OPC_OP_IMM: begin
                    if (stage1_i.funct3 == 3'b100) begin
                        op_o = OP_XORI;
                    end
                end
                OPC_AUIPC: op_o = OP_AUIPC;
                OPC_JAL: op_o = OP_JAL;
                OPC_BRANCH: begin
                    if (stage1_i.funct3 == BR_BLT) begin
                        op_o = OP_BLT;
                    end
                end
                OPC_LOAD: begin
                    if (stage1_i.funct3 == LD_LB) begin
                        op_o = OP_LB;
                    end
                end
                default: op_o = OP_OTHER;
            endcase
        end
    end

    assign writes_rd = (op_o inside {OP_XORI, OP_AUIPC, OP_JAL, OP_LB}) &&
                       (stage1_i.rd != 5'd0);  // x0 never written

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        rsp_ok_o    <= inst_ok_i;
        rsp_op_o    <= op_o;
        rsp_rd_o    <= stage1_i.rd;
        rsp_rd_we_o <= writes_rd;
    end

endmodule

//--- exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic                clk,
    input  rv32i_pkg::decoded_t stage1_i,
    input  rv32i_pkg::op_kind_t op_i,
    output logic [31:0]         rd_val_o,
    output logic [31:0]         mem_addr_o
);
    import rv32i_pkg::*;

    logic [XLEN-1:0] lb_addr;
    logic [XLEN-1:0] lb_shifted;
    logic [7:0]      lb_byte;
    logic [XLEN-1:0] wb_val;
    logic [XLEN-1:0] addr_val;

    assign lb_addr = stage1_i.rs1_val + stage1_i.imm_i;

    // little-endian byte lane from the low address bits
    assign lb_shifted = stage1_i.mem_word >> {lb_addr[1:0], 3'b000};
    assign lb_byte    = lb_shifted[7:0];

    always_comb begin
        addr_val = '0;
        case (op_i)
            OP_XORI: wb_val = stage1_i.rs1_val ^ stage1_i.imm_i;
            OP_AUIPC: wb_val = stage1_i.pc + stage1_i.imm_u;
            OP_JAL: wb_val = stage1_i.pc + INST_BYTES;  // link value
            OP_LB: begin
                wb_val   = {{(XLEN-8){lb_byte[7]}}, lb_byte};
                addr_val = lb_addr;
            end
            default: wb_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        rd_val_o   <= wb_val;
        mem_addr_o <= addr_val;
    end

endmodule

//--- branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
    input  logic                clk,
    input  rv32i_pkg::decoded_t stage1_i,
    input  rv32i_pkg::op_kind_t op_i,
    output logic [31:0]         next_pc_o
);
    import rv32i_pkg::*;

    logic [XLEN-1:0] seq_pc;
    logic            blt_taken;
    logic [XLEN-1:0] target;

    assign seq_pc    = stage1_i.pc + INST_BYTES;
    assign blt_taken = $signed(stage1_i.rs1_val) < $signed(stage1_i.rs2_val);

    always_comb begin
        case (op_i)
            OP_JAL: target = stage1_i.pc + stage1_i.imm_j;
            OP_BLT: target = blt_taken ? (stage1_i.pc + stage1_i.imm_b) : seq_pc;
            default: target = seq_pc;  // fall through
        endcase
    end

    always_ff @(posedge clk) begin
        next_pc_o <= target;
    end

endmodule

//--- retire_ref_top.sv
`timescale 1ns/100ps

module retire_ref_top (
    input  logic                   clk,
    input  logic                   rst,
    input  rv32i_pkg::retire_req_t req_i,
    output rv32i_pkg::retire_rsp_t rsp_o
);
    import rv32i_pkg::*;

    decoded_t    stage1;
    logic        s1_valid;
    logic        inst_ok;
    op_kind_t    op;
    logic        rsp_valid;
    logic        rsp_ok;
    op_kind_t    rsp_op;
    logic [4:0]  rsp_rd;
    logic        rsp_rd_we;
    logic [31:0] rd_val;
    logic [31:0] mem_addr;
    logic [31:0] next_pc;

    inst_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .stage1_o   (stage1),
        .s1_valid_o (s1_valid)
    );

    inst_validator u_validator (
        .stage1_i  (stage1),
        .inst_ok_o (inst_ok)
    );

    retire_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .stage1_i    (stage1),
        .s1_valid_i  (s1_valid),
        .inst_ok_i   (inst_ok),
        .op_o        (op),
        .rsp_valid_o (rsp_valid),
        .rsp_ok_o    (rsp_ok),
        .rsp_op_o    (rsp_op),
        .rsp_rd_o    (rsp_rd),
        .rsp_rd_we_o (rsp_rd_we)
    );

    exec_unit u_exec (
        .clk        (clk),
        .stage1_i   (stage1),
        .op_i       (op),
        .rd_val_o   (rd_val),
        .mem_addr_o (mem_addr)
    );

    branch_unit u_branch (
        .clk       (clk),
        .stage1_i  (stage1),
        .op_i      (op),
        .next_pc_o (next_pc)
    );

    // response fields all come from stage two registers
    assign rsp_o.valid    = rsp_valid;
    assign rsp_o.inst_ok  = rsp_ok;
    assign rsp_o.op       = rsp_op;
    assign rsp_o.rd       = rsp_rd;
    assign rsp_o.rd_we    = rsp_rd_we;
    assign rsp_o.rd_val   = rd_val;
    assign rsp_o.mem_addr = mem_addr;
    assign rsp_o.next_pc  = next_pc;

endmodule

//--- tb_retire_ref.sv
`timescale 1ns/100ps

module tb_retire_ref;
    import rv32i_pkg::*;

    localparam int NUM_REQ     = 2000;
    localparam int LATENCY     = 2;                  // register stages inside the DUT
    localparam int CYCLE_LIMIT = NUM_REQ * 2 + 50;

    logic        clk = 1'b0;
    logic        rst;
    retire_req_t req_i;
    retire_rsp_t rsp_o;

    logic [31:0] lcg_state = 32'hc9ef;
    int          cycle = 0;
    int          sent = 0;
    int          checked = 0;
    retire_rsp_t exp_q[$];
    int          due_q[$];   // cycle on which each response is due

    retire_ref_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .req_i (req_i),
        .rsp_o (rsp_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low LCG bits are weak so only the upper halves are kept
    function automatic logic [31:0] rand_word();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        return {a[31:16], b[31:16]};
    endfunction

    function automatic logic [31:0] make_inst();
        logic [31:0] w;
        logic [31:0] pick;
        w = rand_word();
        pick = rand_word() % 10;
        case (pick)
            0, 1: begin
                // leave the word fully random
            end
            2, 3: begin
                w[6:0]   = OPC_OP_IMM;
                w[14:12] = 3'b100;  // xori
            end
            4: w[6:0] = OPC_AUIPC;
            5: begin
                w[6:0] = OPC_JAL;
                w[21]  = 1'b0;  // target bit 1
            end
            6, 7: begin
                w[6:0]   = OPC_BRANCH;
                w[14:12] = 3'b100;  // blt
                w[8]     = 1'b0;    // offset bit 1
            end
            default: begin
                w[6:0]   = OPC_LOAD;
                w[14:12] = 3'b000;  // lb
            end
        endcase
        return w;
    endfunction

    // RV32I encoding rules read straight from the instruction bits
    function automatic logic is_legal(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: return 1'b1;
            OPC_JAL: return w[21] == 1'b0;
            OPC_JALR: return (f3 == 3'b000) && (w[21:20] == 2'b00);
            OPC_BRANCH: return (f3 != 3'b010) && (f3 != 3'b011) && (w[8] == 1'b0);
            OPC_LOAD: return (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
            OPC_STORE: return f3 <= 3'b010;
            OPC_OP_IMM: begin
                if (f3 == 3'b001) return f7 == 7'h00;
                if (f3 == 3'b101) return (f7 == 7'h00) || (f7 == 7'h20);
                return 1'b1;
            end
            OPC_OP: return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101));
            OPC_FENCE: return ((w[31:28] == 4'h0) && (w[19:7] == 13'h0)) || (w == 32'h0000100f);
            OPC_SYSTEM: return (w[31:21] == 11'h0) && (w[19:7] == 13'h0);
            default: return 1'b0;
        endcase
    endfunction

    function automatic retire_rsp_t predict(input retire_req_t req);
        retire_rsp_t rsp;
        logic [31:0] w;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [7:0]  lane;
        w     = req.inst;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        addr  = req.rs1_val + imm_i;
        case (addr[1:0])
            2'd0: lane = req.mem_word[7:0];
            2'd1: lane = req.mem_word[15:8];
            2'd2: lane = req.mem_word[23:16];
            default: lane = req.mem_word[31:24];
        endcase
        rsp.valid    = 1'b1;
        rsp.inst_ok  = is_legal(w);
        rsp.rd       = w[11:7];
        rsp.op       = OP_OTHER;
        rsp.rd_val   = 32'h0;
        rsp.mem_addr = 32'h0;
        rsp.next_pc  = req.pc + 32'd4;
        if (rsp.inst_ok) begin
            if (w[6:0] == OPC_OP_IMM && w[14:12] == 3'b100) rsp.op = OP_XORI;
            else if (w[6:0] == OPC_AUIPC) rsp.op = OP_AUIPC;
            else if (w[6:0] == OPC_JAL) rsp.op = OP_JAL;
            else if (w[6:0] == OPC_BRANCH && w[14:12] == 3'b100) rsp.op = OP_BLT;
            else if (w[6:0] == OPC_LOAD && w[14:12] == 3'b000) rsp.op = OP_LB;
        end
        case (rsp.op)
            OP_XORI: rsp.rd_val = req.rs1_val ^ imm_i;
            OP_AUIPC: rsp.rd_val = req.pc + {w[31:12], 12'h000};
            OP_JAL: begin
                rsp.rd_val  = req.pc + 32'd4;
                rsp.next_pc = req.pc + imm_j;
            end
            OP_BLT: begin
                if ($signed(req.rs1_val) < $signed(req.rs2_val)) rsp.next_pc = req.pc + imm_b;
            end
            OP_LB: begin
                rsp.rd_val   = {{24{lane[7]}}, lane};
                rsp.mem_addr = addr;
            end
            default: rsp.rd_val = 32'h0;
        endcase
        rsp.rd_we = (rsp.op != OP_BLT) && (rsp.op != OP_OTHER) && (w[11:7] != 5'd0);
        return rsp;
    endfunction

    task automatic abort_run(input string reason);
        if (reason != "") $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s expected %b got %b", $time, name, exp, act);
            abort_run("");
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s expected %h got %h", $time, name, exp, act);
            abort_run("");
        end
    endtask

    task automatic check_op(input string name, input op_kind_t exp, input op_kind_t act);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s expected %s (%0d) got %s (%0d)",
                     $time, name, exp.name(), exp, act.name(), act);
            abort_run("");
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s expected %0d got %0d", $time, name, exp, act);
            abort_run("");
        end
    endtask

    // outputs sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        retire_rsp_t exp;
        if (cycle >= CYCLE_LIMIT) abort_run($sformatf("timeout after %0d cycles", cycle));
        if (!rst) begin
            if (rsp_o.valid === 1'b1) begin
                if (exp_q.size() == 0) abort_run("response seen with no request outstanding");
                if (due_q[0] != cycle) begin
                    abort_run($sformatf("response came on cycle %0d, was due on cycle %0d",
                                        cycle, due_q[0]));
                end
                exp = exp_q.pop_front();
                void'(due_q.pop_front());
                check_flag("rsp_o.inst_ok", exp.inst_ok, rsp_o.inst_ok);
                check_op("rsp_o.op", exp.op, rsp_o.op);
                check_rd("rsp_o.rd", exp.rd, rsp_o.rd);
                check_flag("rsp_o.rd_we", exp.rd_we, rsp_o.rd_we);
                check_word("rsp_o.rd_val", exp.rd_val, rsp_o.rd_val);
                check_word("rsp_o.mem_addr", exp.mem_addr, rsp_o.mem_addr);
                check_word("rsp_o.next_pc", exp.next_pc, rsp_o.next_pc);
                checked++;
            end else if (rsp_o.valid !== 1'b0) begin
                abort_run("rsp_o.valid is unknown after reset");
            end
            if (due_q.size() > 0 && due_q[0] < cycle) begin
                abort_run($sformatf("response due on cycle %0d never arrived", due_q[0]));
            end
        end
    end

    initial begin
        retire_req_t req;
        rst   = 1'b1;
        req_i = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (sent < NUM_REQ) begin
            @(posedge clk);
            req.inst     = make_inst();
            req.pc       = rand_word();
            req.rs1_val  = rand_word();
            req.rs2_val  = rand_word();
            req.mem_word = rand_word();
            req.valid    = (rand_word() % 10) < 7;
            req_i <= req;
            if (req.valid) begin
                exp_q.push_back(predict(req));
                due_q.push_back(cycle + 1 + LATENCY);  // counter still holds the last edge
                sent++;
            end
        end
        @(posedge clk);
        req_i.valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // catch late spurious strobes
        $display("%0d responses checked", checked);
        if (checked == NUM_REQ) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d responses checked", checked, NUM_REQ));
        end
    end

endmodule

//--- verilog.f
rv32i_pkg.sv
inst_decoder.sv
inst_validator.sv
retire_ctrl.sv
exec_unit.sv
branch_unit.sv
retire_ref_top.sv
tb_retire_ref.sv

//--- Makefile
# Verilator build and run for the retire reference unit

VERILATOR ?= verilator
TOP       ?= tb_retire_ref
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
